//--- csr_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_checker (
	input wire clk,
	input wire csr_pkg::csr_req_t req,
	input wire chk_en,
	input wire chk_rdata,
	input wire [`CSR_XLEN-1:0] exp_rdata,
	input wire exp_illegal,
	input wire exp_vld,
	input wire chk_trap,
	input wire [`CSR_XLEN-1:0] exp_addr,
	input wire exp_is_irq,
	input wire [`CSR_XLEN-1:0] rdata,
	input wire illegal,
	input wire trap_enter_vld,
	input wire [`CSR_XLEN-1:0] trap_addr,
	input wire trap_is_irq,
	output int error_count
);

	int errors = 0;

	assign error_count = errors;

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("Error at %0d ns: %s is %h, expected %h (csr %h)",
			$time, what, got, want, req.addr);
	endtask

	// ------------------------------
	// Outputs are settled half a cycle after the inputs change
	always @(negedge clk) begin
		if (chk_en) begin
			if (illegal !== exp_illegal)
				report_mismatch("illegal", 32'(illegal), 32'(exp_illegal));
			// Read data only matters on a legal read
			if (chk_rdata && rdata !== exp_rdata)
				report_mismatch("rdata", rdata, exp_rdata);
			if (trap_enter_vld !== exp_vld)
				report_mismatch("trap_enter_vld", 32'(trap_enter_vld), 32'(exp_vld));
			// Target and kind only while a trap is expected
			if (chk_trap) begin
				if (trap_addr !== exp_addr)
					report_mismatch("trap_addr", trap_addr, exp_addr);
				if (trap_is_irq !== exp_is_irq)
					report_mismatch("trap_is_irq", 32'(trap_is_irq), 32'(exp_is_irq));
			end
		end
	end

endmodule

`default_nettype wire

//--- csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_counters #(
	parameter int W_COUNTER = `CSR_W_COUNTER
) (
	input wire clk,
	input wire rst_n,
	input wire csr_pkg::csr_req_t req,
	input wire instr_ret,
	output csr_pkg::csr_rsp_t rsp
);

	localparam int W_FULL = 2 * `CSR_XLEN;
	// Bits under this mask count, the rest hold
	localparam logic [W_FULL-1:0] CNT_MASK = ~({W_FULL{1'b1}} << W_COUNTER);

	logic [W_FULL-1:0] mcycle;
	logic [W_FULL-1:0] minstret;
	logic [W_FULL-1:0] cy_nxt;
	logic [W_FULL-1:0] ir_nxt;
	logic inhibit_cy;
	logic inhibit_ir;
	logic [`CSR_XLEN-1:0] inhibit_rd;
	logic [`CSR_XLEN-1:0] inhibit_wr;

	function automatic logic [W_FULL-1:0] cnt_inc(input logic [W_FULL-1:0] cnt);
		return ((cnt + 1'b1) & CNT_MASK) | (cnt & ~CNT_MASK);
	endfunction

	assign inhibit_rd = {29'h0, inhibit_ir, 1'b0, inhibit_cy};
	assign inhibit_wr = csr_pkg::csr_update(inhibit_rd, req, 32'h0000_0005);

	// ------------------------------
	// Next counter values
	// Software write to a half beats the increment
	always_comb begin
		cy_nxt = inhibit_cy ? mcycle : cnt_inc(mcycle);
		ir_nxt = (!inhibit_ir && instr_ret) ? cnt_inc(minstret) : minstret;
		if (req.wen) begin
			case (req.addr)
				csr_pkg::MCYCLE:
					cy_nxt[31:0] = csr_pkg::csr_update(mcycle[31:0], req, '1);
				csr_pkg::MCYCLEH:
					cy_nxt[63:32] = csr_pkg::csr_update(mcycle[63:32], req, '1);
				csr_pkg::MINSTRET:
					ir_nxt[31:0] = csr_pkg::csr_update(minstret[31:0], req, '1);
				csr_pkg::MINSTRETH:
					ir_nxt[63:32] = csr_pkg::csr_update(minstret[63:32], req, '1);
				default: ;
			endcase
		end
	end

	// Both counters come out of reset inhibited
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle <= '0;
			minstret <= '0;
			inhibit_cy <= 1'b1;
			inhibit_ir <= 1'b1;
		end else begin
			mcycle <= cy_nxt;
			minstret <= ir_nxt;
			if (req.wen && req.addr == csr_pkg::MCOUNTINHIBIT) begin
				inhibit_cy <= inhibit_wr[0];
				inhibit_ir <= inhibit_wr[2];
			end
		end
	end

	// ------------------------------
	// Reads, user views are read-only aliases
	always_comb begin
		rsp = '0;
		rsp.hit = 1'b1;
		case (req.addr)
			csr_pkg::MCYCLE: rsp.rdata = mcycle[31:0];
			csr_pkg::MCYCLEH: rsp.rdata = mcycle[63:32];
			csr_pkg::MINSTRET: rsp.rdata = minstret[31:0];
			csr_pkg::MINSTRETH: rsp.rdata = minstret[63:32];
			csr_pkg::MCOUNTINHIBIT: rsp.rdata = inhibit_rd;
			csr_pkg::CYCLE, csr_pkg::CYCLEH, csr_pkg::INSTRET, csr_pkg::INSTRETH: begin
				rsp.ro = 1'b1;
				rsp.rdata = req.addr[1] ? minstret[31:0] : mcycle[31:0];
				if (req.addr[7])
					rsp.rdata = req.addr[1] ? minstret[63:32] : mcycle[63:32];
			end
			default: rsp.hit = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- csr_irq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_irq_ctrl #(
	parameter int NUM_IRQ = `CSR_NUM_IRQ
) (
	input wire clk,
	input wire rst_n,
	input wire csr_pkg::csr_req_t req,
	input wire [NUM_IRQ-1:0] irq,
	input wire irq_software,
	input wire irq_timer,
	input wire csr_pkg::irq_enables_t irq_en,
	output csr_pkg::irq_status_t irq_st,
	output csr_pkg::csr_rsp_t rsp
);

	logic [NUM_IRQ-1:0] irq_r;
	logic msip_r;
	logic mtip_r;
	logic [`CSR_XLEN-1:0] meip0;
	logic [`CSR_XLEN-1:0] ext_req;
	logic [`CSR_XLEN-1:0] mip;
	logic sw_pend;
	logic tm_pend;
	logic ext_pend;
	logic [4:0] mlei;

	// One register stage on all level inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r <= '0;
			msip_r <= 1'b0;
			mtip_r <= 1'b0;
		end else begin
			irq_r <= irq;
			msip_r <= irq_software;
			mtip_r <= irq_timer;
		end
	end

	assign meip0 = `CSR_XLEN'(irq_r);
	assign ext_req = meip0 & irq_en.meie0;

	// Standard pending bits, meip is the OR of enabled externals
	assign mip = {20'h0, |ext_req, 3'h0, mtip_r, 3'h0, msip_r, 3'h0};

	assign ext_pend = mip[11] && irq_en.mie_meie;
	assign sw_pend = mip[3] && irq_en.mie_msie;
	assign tm_pend = mip[7] && irq_en.mie_mtie;

	assign irq_st.msip = mip[3];
	assign irq_st.mtip = mip[7];
	assign irq_st.meip = mip[11];
	// Ignores mstatus.mie, that gate sits with the trap logic
	assign irq_st.any_enabled = ext_pend || sw_pend || tm_pend;
	// Priority external, then software, then timer
	assign irq_st.irq_code = ext_pend ? 4'd11 :
		sw_pend ? 4'd3 :
		tm_pend ? 4'd7 : 4'd0;

	// Lowest pending and enabled IRQ wins
	always_comb begin
		mlei = 5'd0;
		for (int i = `CSR_XLEN - 1; i >= 0; i--) begin
			if (ext_req[i])
				mlei = 5'(i);
		end
	end

	// ------------------------------
	// Reads, mip writes are legal and ignored
	always_comb begin
		rsp = '0;
		rsp.hit = 1'b1;
		case (req.addr)
			csr_pkg::MIP: rsp.rdata = mip;
			csr_pkg::MEIP0: begin
				rsp.ro = 1'b1;
				rsp.rdata = meip0;
			end
			csr_pkg::MLEI: begin
				rsp.ro = 1'b1;
				rsp.rdata = {25'h0, mlei, 2'b00};
			end
			default: rsp.hit = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- csr_pkg.sv
`default_nettype none

`include "csr_settings.svh"

package csr_pkg;

	// ------------------------------
	// CSR addresses, range ends given for hpm blocks
	typedef enum logic [11:0] {
		MSTATUS = 12'h300, MISA = 12'h301, MIE = 12'h304, MTVEC = 12'h305,
		MSTATUSH = 12'h310, MCOUNTINHIBIT = 12'h320,
		MHPMEVENT3 = 12'h323, MHPMEVENT31 = 12'h33f,
		MSCRATCH = 12'h340, MEPC = 12'h341, MCAUSE = 12'h342, MTVAL = 12'h343,
		MIP = 12'h344,
		MCYCLE = 12'hb00, MINSTRET = 12'hb02,
		MHPMCOUNTER3 = 12'hb03, MHPMCOUNTER31 = 12'hb1f,
		MCYCLEH = 12'hb80, MINSTRETH = 12'hb82,
		MHPMCOUNTER3H = 12'hb83, MHPMCOUNTER31H = 12'hb9f,
		MEIE0 = 12'hbe0,
		CYCLE = 12'hc00, INSTRET = 12'hc02, CYCLEH = 12'hc80, INSTRETH = 12'hc82,
		MVENDORID = 12'hf11, MARCHID = 12'hf12, MIMPID = 12'hf13,
		MHARTID = 12'hf14, MCONFIGPTR = 12'hf15,
		MEIP0 = 12'hfe0, MLEI = 12'hfe4
	} csr_addr_e;

	// Exception codes from the core, mret rides on code 10
	typedef enum logic [3:0] {
		EXCEPT_INSTR_MISALIGN = 4'd0,
		EXCEPT_INSTR_FAULT = 4'd1,
		EXCEPT_INSTR_ILLEGAL = 4'd2,
		EXCEPT_EBREAK = 4'd3,
		EXCEPT_LOAD_FAULT = 4'd5,
		EXCEPT_STORE_FAULT = 4'd7,
		EXCEPT_MRET = 4'd10,
		EXCEPT_ECALL = 4'd11,
		EXCEPT_NONE = 4'd15
	} except_e;

	typedef enum logic [1:0] {
		CSR_WTYPE_W = 2'd0,
		CSR_WTYPE_S = 2'd1,
		CSR_WTYPE_C = 2'd2
	} csr_wtype_e;

	// ------------------------------
	// Bundles between the blocks
	typedef struct packed {
		logic [11:0] addr;
		logic [`CSR_XLEN-1:0] wdata;
		csr_wtype_e wtype;
		logic wen;
		logic ren;
	} csr_req_t;

	// All zeros when the address is not ours
	typedef struct packed {
		logic hit;
		logic ro;
		logic [`CSR_XLEN-1:0] rdata;
	} csr_rsp_t;

	typedef struct packed {
		logic mie_msie;
		logic mie_mtie;
		logic mie_meie;
		logic mstatus_mie;
		logic [`CSR_XLEN-1:0] meie0;
	} irq_enables_t;

	typedef struct packed {
		logic msip;
		logic mtip;
		logic meip;
		logic any_enabled;
		logic [3:0] irq_code;
	} irq_status_t;

	// Write, set or clear applied to the writable bits only
	function automatic logic [`CSR_XLEN-1:0] csr_update(
		input logic [`CSR_XLEN-1:0] prev,
		input csr_req_t req,
		input logic [`CSR_XLEN-1:0] wmask
	);
		logic [`CSR_XLEN-1:0] nxt;
		case (req.wtype)
			CSR_WTYPE_S: nxt = prev | req.wdata;
			CSR_WTYPE_C: nxt = prev & ~req.wdata;
			default: nxt = req.wdata;
		endcase
		return (nxt & wmask) | (prev & ~wmask);
	endfunction

endpackage

`default_nettype wire

//--- csr_read_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_read_port (
	input wire csr_pkg::csr_req_t req,
	input wire csr_pkg::csr_rsp_t trap_rsp,
	input wire csr_pkg::csr_rsp_t irq_rsp,
	input wire csr_pkg::csr_rsp_t cnt_rsp,
	output logic [`CSR_XLEN-1:0] rdata,
	output logic illegal
);

	// MXL 32-bit, X for the custom IRQ CSRs, I, optional C
	localparam logic [`CSR_XLEN-1:0] MISA_VAL = 32'h4080_0100 | (`CSR_EXT_C ? 32'h4 : 32'h0);

	csr_pkg::csr_rsp_t const_rsp;
	csr_pkg::csr_rsp_t all_rsp;

	// ------------------------------
	// Constant and tied-zero CSRs
	// misa is WARL, so writes are legal and dropped
	always_comb begin
		const_rsp = '0;
		const_rsp.hit = 1'b1;
		const_rsp.ro = 1'b1;
		case (req.addr) inside
			csr_pkg::MISA: begin
				const_rsp.ro = 1'b0;
				const_rsp.rdata = MISA_VAL;
			end
			csr_pkg::MVENDORID: const_rsp.rdata = `CSR_MVENDORID_VAL;
			csr_pkg::MARCHID: const_rsp.rdata = `CSR_MARCHID_VAL;
			csr_pkg::MIMPID: const_rsp.rdata = `CSR_MIMPID_VAL;
			csr_pkg::MHARTID: const_rsp.rdata = `CSR_MHARTID_VAL;
			csr_pkg::MCONFIGPTR: const_rsp.rdata = `CSR_MCONFIGPTR_VAL;
			// Little-endian only, so mstatush is all zero
			csr_pkg::MSTATUSH,
			[csr_pkg::MHPMCOUNTER3 : csr_pkg::MHPMCOUNTER31],
			[csr_pkg::MHPMCOUNTER3H : csr_pkg::MHPMCOUNTER31H],
			[csr_pkg::MHPMEVENT3 : csr_pkg::MHPMEVENT31]: const_rsp.ro = 1'b0;
			default: begin
				const_rsp.hit = 1'b0;
				const_rsp.ro = 1'b0;
			end
		endcase
	end

	// Non-decoding sources return zeros, so OR merges cleanly
	assign all_rsp = const_rsp | trap_rsp | irq_rsp | cnt_rsp;
	assign rdata = all_rsp.rdata;

	// Unmapped access, or a write to a read-only CSR
	assign illegal = (req.wen || req.ren) && (!all_rsp.hit || (req.wen && all_rsp.ro));

endmodule

`default_nettype wire

//--- csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath width, RV32 only
`define CSR_XLEN 32

// External IRQ count, 1 to 32, all in meie0
`define CSR_NUM_IRQ 32

// Implemented counter bits, upper bits hold their value
`define CSR_W_COUNTER 64

// ------------------------------
// Reset values and write masks
`define CSR_MTVEC_INIT 32'h0000_0000
// Base bits plus the vectored mode bit
`define CSR_MTVEC_WMASK 32'hffff_fffd
// meie, mtie, msie
`define CSR_MIE_WMASK 32'h0000_0888
// Compressed support, sets mepc alignment to 2 bytes
`define CSR_EXT_C 1

// ------------------------------
// Identity values
`define CSR_MVENDORID_VAL 32'h0000_0000
`define CSR_MARCHID_VAL 32'h0000_001b
`define CSR_MIMPID_VAL 32'h0000_0001
`define CSR_MHARTID_VAL 32'h0000_0000
`define CSR_MCONFIGPTR_VAL 32'h0000_0000

`endif

//--- csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_trap_regs (
	input wire clk,
	input wire rst_n,
	input wire csr_pkg::csr_req_t req,
	input wire csr_pkg::except_e except,
	input wire [`CSR_XLEN-1:0] mepc_in,
	input wire trap_enter_rdy,
	input wire csr_pkg::irq_status_t irq_st,
	output csr_pkg::irq_enables_t irq_en,
	output csr_pkg::csr_rsp_t rsp,
	output logic [`CSR_XLEN-1:0] trap_addr,
	output logic trap_is_irq,
	output logic trap_enter_vld
);

	// mepc holds only aligned instruction addresses
	localparam logic [`CSR_XLEN-1:0] MEPC_MASK = `CSR_EXT_C ? 32'hffff_fffe : 32'hffff_fffc;
	localparam logic [`CSR_XLEN-1:0] MEIE0_WMASK = ~({`CSR_XLEN{1'b1}} << `CSR_NUM_IRQ);

	logic mstatus_mie;
	logic mstatus_mpie;
	logic [`CSR_XLEN-1:0] mscratch;
	logic [`CSR_XLEN-1:0] mtvec;
	logic [`CSR_XLEN-1:0] mepc;
	logic mcause_irq;
	logic [3:0] mcause_code;
	logic [`CSR_XLEN-1:0] mie;
	logic [`CSR_XLEN-1:0] meie0;

	logic [`CSR_XLEN-1:0] mstatus_rd;
	logic [`CSR_XLEN-1:0] mcause_rd;
	logic [`CSR_XLEN-1:0] mstatus_wr;
	logic [`CSR_XLEN-1:0] mcause_wr;
	logic except_req;
	logic is_mret;
	logic irq_active;
	logic trap_take;
	logic [3:0] vector_sel;

	assign mstatus_rd = {24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0};
	assign mcause_rd = {mcause_irq, 27'h0, mcause_code};
	assign mstatus_wr = csr_pkg::csr_update(mstatus_rd, req, 32'h0000_0088);
	assign mcause_wr = csr_pkg::csr_update(mcause_rd, req, 32'h8000_000f);

	// ------------------------------
	// Trap request
	// Any exception code, mret included, beats a pending interrupt
	assign except_req = except != csr_pkg::EXCEPT_NONE;
	assign is_mret = except == csr_pkg::EXCEPT_MRET;
	assign irq_active = mstatus_mie && irq_st.any_enabled;
	assign trap_enter_vld = except_req || irq_active;
	assign trap_is_irq = !except_req;
	assign trap_take = trap_enter_vld && trap_enter_rdy;

	// Vectored mode offsets only interrupts
	assign vector_sel = (trap_is_irq && mtvec[0]) ? irq_st.irq_code : 4'h0;
	assign trap_addr = is_mret ? mepc :
		{mtvec[`CSR_XLEN-1:2], 2'b00} + {26'h0, vector_sel, 2'b00};

	// Two-level enable stack, trap update beats software write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (trap_take) begin
			if (is_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end else begin
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end
		end else if (req.wen && req.addr == csr_pkg::MSTATUS) begin
			mstatus_mie <= mstatus_wr[3];
			mstatus_mpie <= mstatus_wr[7];
		end
	end

	// mepc and mcause capture on entry, mret leaves them alone
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc <= '0;
			mcause_irq <= 1'b0;
			mcause_code <= 4'h0;
		end else if (trap_take && !is_mret) begin
			mepc <= mepc_in & MEPC_MASK;
			mcause_irq <= trap_is_irq;
			mcause_code <= except_req ? 4'(except) : irq_st.irq_code;
		end else if (req.wen) begin
			if (req.addr == csr_pkg::MEPC)
				mepc <= csr_pkg::csr_update(mepc, req, MEPC_MASK);
			if (req.addr == csr_pkg::MCAUSE) begin
				mcause_irq <= mcause_wr[31];
				mcause_code <= mcause_wr[3:0];
			end
		end
	end

	// Plain software registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch <= '0;
			mtvec <= `CSR_MTVEC_INIT;
			mie <= '0;
			meie0 <= '0;
		end else if (req.wen) begin
			case (req.addr)
				csr_pkg::MSCRATCH: mscratch <= csr_pkg::csr_update(mscratch, req, '1);
				csr_pkg::MTVEC: mtvec <= csr_pkg::csr_update(mtvec, req, `CSR_MTVEC_WMASK);
				csr_pkg::MIE: mie <= csr_pkg::csr_update(mie, req, `CSR_MIE_WMASK);
				csr_pkg::MEIE0: meie0 <= csr_pkg::csr_update(meie0, req, MEIE0_WMASK);
				default: ;
			endcase
		end
	end

	assign irq_en.mie_msie = mie[3];
	assign irq_en.mie_mtie = mie[7];
	assign irq_en.mie_meie = mie[11];
	assign irq_en.mstatus_mie = mstatus_mie;
	assign irq_en.meie0 = meie0;

	// ------------------------------
	// Read decode, mtval is tied to zero
	always_comb begin
		rsp = '0;
		rsp.hit = 1'b1;
		case (req.addr)
			csr_pkg::MSTATUS: rsp.rdata = mstatus_rd;
			csr_pkg::MSCRATCH: rsp.rdata = mscratch;
			csr_pkg::MTVEC: rsp.rdata = mtvec;
			csr_pkg::MEPC: rsp.rdata = mepc;
			csr_pkg::MCAUSE: rsp.rdata = mcause_rd;
			csr_pkg::MTVAL: rsp.rdata = '0;
			csr_pkg::MIE: rsp.rdata = mie;
			csr_pkg::MEIE0: rsp.rdata = meie0;
			default: rsp.hit = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit (
	input wire clk,
	input wire rst_n,
	input wire csr_pkg::csr_req_t req,
	output logic [`CSR_XLEN-1:0] rdata,
	output logic illegal,
	input wire csr_pkg::except_e except,
	input wire [`CSR_XLEN-1:0] mepc_in,
	input wire [`CSR_NUM_IRQ-1:0] irq,
	input wire irq_software,
	input wire irq_timer,
	input wire instr_ret,
	output logic [`CSR_XLEN-1:0] trap_addr,
	output logic trap_is_irq,
	output logic trap_enter_vld,
	input wire trap_enter_rdy
);

	csr_pkg::irq_enables_t irq_en;
	csr_pkg::irq_status_t irq_st;
	csr_pkg::csr_rsp_t trap_rsp;
	csr_pkg::csr_rsp_t irq_rsp;
	csr_pkg::csr_rsp_t cnt_rsp;

	// Trap CSRs and trap request
	csr_trap_regs u_trap_regs (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.except(except),
		.mepc_in(mepc_in),
		.trap_enter_rdy(trap_enter_rdy),
		.irq_st(irq_st),
		.irq_en(irq_en),
		.rsp(trap_rsp),
		.trap_addr(trap_addr),
		.trap_is_irq(trap_is_irq),
		.trap_enter_vld(trap_enter_vld)
	);

	// Pending state and interrupt priority
	csr_irq_ctrl #(
		.NUM_IRQ(`CSR_NUM_IRQ)
	) u_irq_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.irq(irq),
		.irq_software(irq_software),
		.irq_timer(irq_timer),
		.irq_en(irq_en),
		.irq_st(irq_st),
		.rsp(irq_rsp)
	);

	csr_counters #(
		.W_COUNTER(`CSR_W_COUNTER)
	) u_counters (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.instr_ret(instr_ret),
		.rsp(cnt_rsp)
	);

	// Constants, merge and illegal detection
	csr_read_port u_read_port (
		.req(req),
		.trap_rsp(trap_rsp),
		.irq_rsp(irq_rsp),
		.cnt_rsp(cnt_rsp),
		.rdata(rdata),
		.illegal(illegal)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
csr_pkg.sv
csr_trap_regs.sv
csr_irq_ctrl.sv
csr_counters.sv
csr_read_port.sv
csr_unit.sv
csr_checker.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_csr_unit -f project.f \
	&& ./obj_dir/Vtb_csr_unit | tee /dev/stderr | grep -qx "Simulation PASSED" \
	&& echo "run_sim: pass" \
	|| { echo "run_sim: fail"; exit 1; }

//--- tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module tb_csr_unit;

	localparam int VLD_TIMEOUT = 20;
	localparam logic [31:0] MEPC_ALIGN = `CSR_EXT_C ? 32'hffff_fffe : 32'hffff_fffc;
	// Return address handed over with every trap has its low bits set
	localparam logic [31:0] EPC = 32'h0000_2003;
	localparam logic [`CSR_NUM_IRQ-1:0] IRQ_LINES = `CSR_NUM_IRQ'((1 << 5) | (1 << 9));

	// One table row with the DUT inputs first and the expected outputs after
	typedef struct packed {
		csr_pkg::csr_req_t req;
		csr_pkg::except_e except;
		logic [31:0] mepc_in;
		logic [`CSR_NUM_IRQ-1:0] irq;
		logic irq_software;
		logic irq_timer;
		logic instr_ret;
		logic rdy;
		logic wait_vld;
		logic chk_rdata;
		logic [31:0] exp_rdata;
		logic exp_illegal;
		logic exp_vld;
		logic chk_trap;
		logic [31:0] exp_addr;
		logic exp_is_irq;
	} row_t;

	logic clk;
	logic rst_n;
	csr_pkg::csr_req_t req;
	csr_pkg::except_e except;
	logic [31:0] mepc_in;
	logic [`CSR_NUM_IRQ-1:0] irq;
	logic irq_software;
	logic irq_timer;
	logic instr_ret;
	logic trap_enter_rdy;
	logic [31:0] rdata;
	logic illegal;
	logic [31:0] trap_addr;
	logic trap_is_irq;
	logic trap_enter_vld;

	// Expected values for the checker
	logic chk_en;
	logic chk_rdata;
	logic [31:0] exp_rdata;
	logic exp_illegal;
	logic exp_vld;
	logic chk_trap;
	logic [31:0] exp_addr;
	logic exp_is_irq;
	int error_count;
	int timeouts;

	row_t table_q[$];

	initial clk = 1'b0;
	always #20 clk = ~clk;

	csr_unit dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.rdata(rdata),
		.illegal(illegal),
		.except(except),
		.mepc_in(mepc_in),
		.irq(irq),
		.irq_software(irq_software),
		.irq_timer(irq_timer),
		.instr_ret(instr_ret),
		.trap_addr(trap_addr),
		.trap_is_irq(trap_is_irq),
		.trap_enter_vld(trap_enter_vld),
		.trap_enter_rdy(trap_enter_rdy)
	);

	csr_checker check_i (
		.clk(clk),
		.req(req),
		.chk_en(chk_en),
		.chk_rdata(chk_rdata),
		.exp_rdata(exp_rdata),
		.exp_illegal(exp_illegal),
		.exp_vld(exp_vld),
		.chk_trap(chk_trap),
		.exp_addr(exp_addr),
		.exp_is_irq(exp_is_irq),
		.rdata(rdata),
		.illegal(illegal),
		.trap_enter_vld(trap_enter_vld),
		.trap_addr(trap_addr),
		.trap_is_irq(trap_is_irq),
		.error_count(error_count)
	);

	// ------------------------------
	// Row builders
	function automatic row_t idle_row();
		row_t r;
		r = '0;
		r.except = csr_pkg::EXCEPT_NONE;
		return r;
	endfunction

	function automatic row_t read_row(input logic [11:0] addr, input logic [31:0] value);
		row_t r;
		r = idle_row();
		r.req.addr = addr;
		r.req.ren = 1'b1;
		r.chk_rdata = 1'b1;
		r.exp_rdata = value;
		return r;
	endfunction

	function automatic row_t write_row(input logic [11:0] addr, input csr_pkg::csr_wtype_e wtype,
		input logic [31:0] data);
		row_t r;
		r = idle_row();
		r.req.addr = addr;
		r.req.wen = 1'b1;
		r.req.wtype = wtype;
		r.req.wdata = data;
		return r;
	endfunction

	// Read or write access that must raise illegal
	function automatic row_t bad_row(input logic [11:0] addr, input logic wen);
		row_t r;
		r = idle_row();
		r.req.addr = addr;
		r.req.wen = wen;
		r.req.ren = !wen;
		r.req.wdata = 32'hdead_beef;
		r.exp_illegal = 1'b1;
		return r;
	endfunction

	// Adds a pending trap and its expected target to a row
	function automatic row_t trap_row(input row_t base, input csr_pkg::except_e code,
		input logic rdy, input logic [31:0] target, input logic is_irq);
		row_t r;
		r = base;
		r.except = code;
		r.mepc_in = EPC;
		r.rdy = rdy;
		r.exp_vld = 1'b1;
		r.chk_trap = 1'b1;
		r.exp_addr = target;
		r.exp_is_irq = is_irq;
		return r;
	endfunction

	task automatic build_table();
		row_t r;
		logic [31:0] rnd;
		int pulses;
		// Reset values with both counters inhibited
		table_q.push_back(read_row(csr_pkg::MSTATUS, 32'h0));
		table_q.push_back(read_row(csr_pkg::MTVEC, `CSR_MTVEC_INIT));
		table_q.push_back(read_row(csr_pkg::MEPC, 32'h0));
		table_q.push_back(read_row(csr_pkg::MCAUSE, 32'h0));
		table_q.push_back(read_row(csr_pkg::MIE, 32'h0));
		table_q.push_back(read_row(csr_pkg::MEIE0, 32'h0));
		table_q.push_back(read_row(csr_pkg::MIP, 32'h0));
		table_q.push_back(read_row(csr_pkg::MTVAL, 32'h0));
		table_q.push_back(read_row(csr_pkg::MSCRATCH, 32'h0));
		table_q.push_back(read_row(csr_pkg::MCOUNTINHIBIT, 32'h5));
		// Write, set, clear on mscratch
		table_q.push_back(write_row(csr_pkg::MSCRATCH, csr_pkg::CSR_WTYPE_W, 32'h1234_5678));
		table_q.push_back(read_row(csr_pkg::MSCRATCH, 32'h1234_5678));
		table_q.push_back(write_row(csr_pkg::MSCRATCH, csr_pkg::CSR_WTYPE_S, 32'h0000_ff00));
		table_q.push_back(read_row(csr_pkg::MSCRATCH, 32'h1234_ff78));
		table_q.push_back(write_row(csr_pkg::MSCRATCH, csr_pkg::CSR_WTYPE_C, 32'h1200_0008));
		table_q.push_back(read_row(csr_pkg::MSCRATCH, 32'h1234_ff78 & ~32'h1200_0008));
		// Only msie, mtie and meie survive
		rnd = $urandom();
		table_q.push_back(write_row(csr_pkg::MIE, csr_pkg::CSR_WTYPE_W, rnd));
		table_q.push_back(read_row(csr_pkg::MIE, rnd & 32'h0000_0888));
		table_q.push_back(write_row(csr_pkg::MIE, csr_pkg::CSR_WTYPE_C, '1));
		table_q.push_back(write_row(csr_pkg::MTVEC, csr_pkg::CSR_WTYPE_W, '1));
		table_q.push_back(read_row(csr_pkg::MTVEC, `CSR_MTVEC_WMASK));
		table_q.push_back(write_row(csr_pkg::MTVEC, csr_pkg::CSR_WTYPE_W, 32'h0000_1000));
		table_q.push_back(read_row(csr_pkg::MTVEC, 32'h0000_1000));
		table_q.push_back(write_row(csr_pkg::MEPC, csr_pkg::CSR_WTYPE_W, '1));
		table_q.push_back(read_row(csr_pkg::MEPC, MEPC_ALIGN));

		// ------------------------------
		// Illegal and tolerated accesses
		table_q.push_back(bad_row(12'h7c0, 1'b0));
		table_q.push_back(bad_row(12'h7c0, 1'b1));
		table_q.push_back(bad_row(csr_pkg::MVENDORID, 1'b1));
		table_q.push_back(bad_row(csr_pkg::CYCLE, 1'b1));
		table_q.push_back(bad_row(csr_pkg::MLEI, 1'b1));
		table_q.push_back(read_row(csr_pkg::MVENDORID, `CSR_MVENDORID_VAL));
		table_q.push_back(read_row(csr_pkg::MARCHID, `CSR_MARCHID_VAL));
		table_q.push_back(read_row(csr_pkg::CYCLE, 32'h0));
		table_q.push_back(read_row(csr_pkg::MLEI, 32'h0));
		table_q.push_back(read_row(12'hb10, 32'h0));
		table_q.push_back(read_row(12'hb85, 32'h0));
		table_q.push_back(read_row(12'h330, 32'h0));
		table_q.push_back(write_row(12'hb10, csr_pkg::CSR_WTYPE_W, rnd));
		table_q.push_back(write_row(12'h33f, csr_pkg::CSR_WTYPE_S, rnd));
		table_q.push_back(write_row(csr_pkg::MSTATUSH, csr_pkg::CSR_WTYPE_W, rnd));
		table_q.push_back(read_row(csr_pkg::MSTATUSH, 32'h0));

		// ------------------------------
		// ecall held off twice and then taken
		table_q.push_back(write_row(csr_pkg::MSTATUS, csr_pkg::CSR_WTYPE_S, 32'h8));
		table_q.push_back(read_row(csr_pkg::MSTATUS, 32'h8));
		table_q.push_back(trap_row(read_row(csr_pkg::MSTATUS, 32'h8), csr_pkg::EXCEPT_ECALL,
			1'b0, 32'h0000_1000, 1'b0));
		table_q.push_back(trap_row(read_row(csr_pkg::MEPC, MEPC_ALIGN), csr_pkg::EXCEPT_ECALL,
			1'b0, 32'h0000_1000, 1'b0));
		table_q.push_back(trap_row(read_row(csr_pkg::MCAUSE, 32'h0), csr_pkg::EXCEPT_ECALL,
			1'b1, 32'h0000_1000, 1'b0));
		table_q.push_back(read_row(csr_pkg::MEPC, EPC & MEPC_ALIGN));
		table_q.push_back(read_row(csr_pkg::MCAUSE, 32'd11));
		table_q.push_back(read_row(csr_pkg::MSTATUS, 32'h80));
		// mret jumps back to mepc and restores MIE
		table_q.push_back(trap_row(read_row(csr_pkg::MSTATUS, 32'h80), csr_pkg::EXCEPT_MRET,
			1'b0, EPC & MEPC_ALIGN, 1'b0));
		table_q.push_back(trap_row(read_row(csr_pkg::MEPC, EPC & MEPC_ALIGN),
			csr_pkg::EXCEPT_MRET, 1'b1, EPC & MEPC_ALIGN, 1'b0));
		table_q.push_back(read_row(csr_pkg::MSTATUS, 32'h88));

		// ------------------------------
		// Vectored external interrupt on lines 5 and 9
		table_q.push_back(write_row(csr_pkg::MTVEC, csr_pkg::CSR_WTYPE_W, 32'h0000_4001));
		table_q.push_back(write_row(csr_pkg::MEIE0, csr_pkg::CSR_WTYPE_W, 32'(IRQ_LINES)));
		table_q.push_back(write_row(csr_pkg::MIE, csr_pkg::CSR_WTYPE_S, 32'h800));
		r = read_row(csr_pkg::MIP, 32'h0);
		r.irq = IRQ_LINES;
		table_q.push_back(r);
		// Request must be up exactly one cycle after the lines rise
		r = trap_row(idle_row(), csr_pkg::EXCEPT_NONE, 1'b0, 32'h0000_4000 + 4 * 11, 1'b1);
		r.irq = IRQ_LINES;
		r.wait_vld = 1'b1;
		table_q.push_back(r);
		r = trap_row(read_row(csr_pkg::MLEI, 32'd20), csr_pkg::EXCEPT_NONE, 1'b0,
			32'h0000_4000 + 4 * 11, 1'b1);
		r.irq = IRQ_LINES;
		table_q.push_back(r);
		r = trap_row(read_row(csr_pkg::MEIP0, 32'(IRQ_LINES)), csr_pkg::EXCEPT_NONE, 1'b1,
			32'h0000_4000 + 4 * 11, 1'b1);
		r.irq = IRQ_LINES;
		table_q.push_back(r);
		table_q.push_back(read_row(csr_pkg::MCAUSE, 32'h8000_000b));
		table_q.push_back(read_row(csr_pkg::MSTATUS, 32'h80));

		// ------------------------------
		// Counters stay frozen until the inhibit bits clear
		r = read_row(csr_pkg::MCYCLE, 32'h0);
		r.instr_ret = 1'b1;
		table_q.push_back(r);
		table_q.push_back(read_row(csr_pkg::MINSTRET, 32'h0));
		table_q.push_back(write_row(csr_pkg::MCOUNTINHIBIT, csr_pkg::CSR_WTYPE_C, 32'h4));
		pulses = 0;
		for (int i = 0; i < 8; i++) begin
			r = idle_row();
			r.instr_ret = 1'($urandom());
			pulses += int'(r.instr_ret);
			table_q.push_back(r);
		end
		table_q.push_back(read_row(csr_pkg::MINSTRET, 32'(pulses)));
		table_q.push_back(read_row(csr_pkg::MINSTRETH, 32'h0));
		// Low half at all ones carries on the next count
		table_q.push_back(write_row(csr_pkg::MCOUNTINHIBIT, csr_pkg::CSR_WTYPE_C, 32'h1));
		table_q.push_back(write_row(csr_pkg::MCYCLE, csr_pkg::CSR_WTYPE_W, '1));
		table_q.push_back(read_row(csr_pkg::MCYCLE, 32'hffff_ffff));
		table_q.push_back(read_row(csr_pkg::MCYCLEH, 32'h1));
		table_q.push_back(read_row(csr_pkg::CYCLE, 32'h1));
	endtask

	// ------------------------------
	// Drive one row on the rising edge
	task automatic apply_row(input row_t r);
		@(posedge clk);
		req <= r.req;
		except <= r.except;
		mepc_in <= r.mepc_in;
		irq <= r.irq;
		irq_software <= r.irq_software;
		irq_timer <= r.irq_timer;
		instr_ret <= r.instr_ret;
		trap_enter_rdy <= r.rdy;
		chk_en <= 1'b1;
		chk_rdata <= r.chk_rdata;
		exp_rdata <= r.exp_rdata;
		exp_illegal <= r.exp_illegal;
		exp_vld <= r.exp_vld;
		chk_trap <= r.chk_trap;
		exp_addr <= r.exp_addr;
		exp_is_irq <= r.exp_is_irq;
	endtask

	// Inputs hold while polling at the falling edge
	task automatic wait_for_vld(output logic seen);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!trap_enter_vld && cycles < VLD_TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		seen = trap_enter_vld;
	endtask

	initial begin
		row_t r;
		logic seen;
		void'($urandom(32'h9a9d));
		rst_n = 1'b0;
		req = '0;
		except = csr_pkg::EXCEPT_NONE;
		mepc_in = '0;
		irq = '0;
		irq_software = 1'b0;
		irq_timer = 1'b0;
		instr_ret = 1'b0;
		trap_enter_rdy = 1'b0;
		chk_en = 1'b0;
		chk_rdata = 1'b0;
		exp_rdata = '0;
		exp_illegal = 1'b0;
		exp_vld = 1'b0;
		chk_trap = 1'b0;
		exp_addr = '0;
		exp_is_irq = 1'b0;
		timeouts = 0;
		build_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < table_q.size(); i++) begin
			r = table_q[i];
			if (timeouts == 0) begin
				apply_row(r);
				if (r.wait_vld) begin
					wait_for_vld(seen);
					if (!seen) begin
						$display("Timeout: trap_enter_vld stayed low for %0d cycles at row %0d",
							VLD_TIMEOUT, i);
						timeouts++;
					end
				end
			end
		end

		// Let the last row be checked before reading the count
		@(posedge clk);
		chk_en <= 1'b0;
		@(posedge clk);
		$display("Done: %0d mismatches, %0d timeouts", error_count, timeouts);
		if (error_count == 0 && timeouts == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
